// ==== Bender.yml ====
package:
  name: xbar_rd

sources:
  - include_dirs:
      - source
    files:
      - source/xbar_pkg.sv
      - source/xbar_addr_decode.sv
      - source/xbar_rd_demux.sv
      - source/xbar_err_slv.sv
      - source/xbar_rd_mux.sv
      - source/xbar_rd_top.sv
  - target: test
    files:
      - verif/tb_xbar.sv

// ==== sources.f ====
+incdir+source
source/xbar_pkg.sv
source/xbar_addr_decode.sv
source/xbar_rd_demux.sv
source/xbar_err_slv.sv
source/xbar_rd_mux.sv
source/xbar_rd_top.sv
verif/tb_xbar.sv

// ==== verif/tb_xbar.sv ====
/*
  Directed testbench for the read crossbar.
  Two target memory models with random response delays, one task per test,
  in-order response checking per initiator port and a cycle timeout.
*/
`timescale 1ns/100ps
`include "xbar_config.svh"

module tb_xbar;

  localparam int max_cycles = 2000;

  logic clk_i;
  logic rst_n_i;
  logic              [1:0] slv_ar_valid, slv_ar_ready, slv_r_valid, slv_r_ready;
  xbar_pkg::addr_t   [1:0] slv_ar_addr;
  xbar_pkg::slv_id_t [1:0] slv_ar_id, slv_r_id;
  xbar_pkg::data_t   [1:0] slv_r_data;
  xbar_pkg::resp_t   [1:0] slv_r_resp;
  logic              [1:0] mst_ar_valid, mst_ar_ready, mst_r_valid, mst_r_ready;
  xbar_pkg::addr_t   [1:0] mst_ar_addr;
  xbar_pkg::mst_id_t [1:0] mst_ar_id, mst_r_id;
  xbar_pkg::data_t   [1:0] mst_r_data;
  xbar_pkg::resp_t   [1:0] mst_r_resp;

  int          cycle_cnt = 0;
  int          err_cnt = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  logic [31:0] lcg_state = 32'haf2ba8ed;

  // Expected and received responses per initiator port, in issue order
  logic [31:0] exp_data[2][64];
  logic [1:0]  exp_resp[2][64];
  logic [1:0]  exp_id[2][64];
  logic [31:0] rx_data[2][64];
  logic [1:0]  rx_resp[2][64];
  logic [1:0]  rx_id[2][64];
  int          exp_cnt[2] = '{0, 0};
  int          rx_cnt[2] = '{0, 0};
  int          chk_idx[2] = '{0, 0};

  // Random read lists, drawn before both ports start
  logic [31:0] rnd_addr[2][10];
  logic [1:0]  rnd_id[2][10];

  // Target model state
  logic [31:0]       pa_addr[2][16];
  xbar_pkg::mst_id_t pa_id[2][16];
  int                pa_due[2][16];
  int                hd[2] = '{0, 0};
  int                tl[2] = '{0, 0};
  int                last_due[2] = '{0, 0};
  int                ar_seen[2] = '{0, 0};
  logic              last_src[2];
  bit                ar_hit[2];
  bit                r_hit[2];
  logic [31:0]       cap_addr[2];
  xbar_pkg::mst_id_t cap_id[2];
  int                cap_dly[2];

  xbar_rd_top UUT (
    .clk_i, .rst_n_i,
    .slv_ar_valid_i (slv_ar_valid), .slv_ar_addr_i  (slv_ar_addr),
    .slv_ar_id_i    (slv_ar_id),    .slv_ar_ready_o (slv_ar_ready),
    .slv_r_valid_o  (slv_r_valid),  .slv_r_data_o   (slv_r_data),
    .slv_r_resp_o   (slv_r_resp),   .slv_r_id_o     (slv_r_id),
    .slv_r_ready_i  (slv_r_ready),
    .mst_ar_valid_o (mst_ar_valid), .mst_ar_addr_o  (mst_ar_addr),
    .mst_ar_id_o    (mst_ar_id),    .mst_ar_ready_i (mst_ar_ready),
    .mst_r_valid_i  (mst_r_valid),  .mst_r_data_i   (mst_r_data),
    .mst_r_resp_i   (mst_r_resp),   .mst_r_id_i     (mst_r_id),
    .mst_r_ready_o  (mst_r_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == max_cycles) begin
      $display("Timeout after %0d cycles, a response never arrived", max_cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Region rule, 2 stands for unmapped
  function automatic int expected_target(logic [31:0] addr);
    if (addr >= `XBAR_MST0_BASE && addr < `XBAR_MST0_END) return 0;
    if (addr >= `XBAR_MST1_BASE && addr < `XBAR_MST1_END) return 1;
    return 2;
  endfunction

  // Memory models, responses leave in acceptance order
  initial begin
    int k;
    mst_ar_ready = 2'b11;
    mst_r_valid  = '0;
    mst_r_data   = '0;
    mst_r_resp   = '0;
    mst_r_id     = '0;
    forever begin
      // Requests are captured mid-cycle, the transfer happens at the next edge
      @(negedge clk_i);
      for (int j = 0; j < 2; j++) begin
        ar_hit[j]   = rst_n_i && mst_ar_valid[j];
        r_hit[j]    = rst_n_i && mst_r_valid[j] && mst_r_ready[j];
        cap_addr[j] = mst_ar_addr[j];
        cap_id[j]   = mst_ar_id[j];
        if (ar_hit[j]) cap_dly[j] = 1 + int'(lcg_next() % 3);
      end
      @(posedge clk_i);
      #10;
      for (int j = 0; j < 2; j++) begin
        if (r_hit[j]) hd[j]++;
        if (ar_hit[j]) begin
          k = tl[j] % 16;
          pa_addr[j][k] = cap_addr[j];
          pa_id[j][k]   = cap_id[j];
          last_due[j]   = ((cycle_cnt > last_due[j]) ? cycle_cnt : last_due[j]) + cap_dly[j];
          pa_due[j][k]  = last_due[j];
          last_src[j]   = cap_id[j].fields.src;
          ar_seen[j]++;
          tl[j]++;
        end
        k = hd[j] % 16;
        mst_r_valid[j] = (hd[j] != tl[j]) && (cycle_cnt >= pa_due[j][k]);
        mst_r_data[j]  = pa_addr[j][k] ^ (32'h5A5A_0000 + j);
        mst_r_resp[j]  = `XBAR_RESP_OKAY;
        mst_r_id[j]    = pa_id[j][k];
      end
    end
  end

  // R handshakes are sampled mid-cycle, the transfer happens at the next edge
  initial begin
    forever begin
      @(negedge clk_i);
      for (int p = 0; p < 2; p++) begin
        if (rst_n_i && slv_r_valid[p] && slv_r_ready[p]) begin
          rx_data[p][rx_cnt[p]] = slv_r_data[p];
          rx_resp[p][rx_cnt[p]] = slv_r_resp[p];
          rx_id[p][rx_cnt[p]]   = slv_r_id[p];
          rx_cnt[p]++;
        end
      end
    end
  end

  task automatic report_error(string msg);
    $display("[ERROR] %0t %s", $time, msg);
    err_cnt++;
  endtask

  // Starts and ends 10 ns after a rising edge
  task automatic issue_ar(int p, logic [31:0] addr, logic [1:0] id);
    int tgt;
    tgt = expected_target(addr);
    exp_data[p][exp_cnt[p]] = (tgt == 2) ? `XBAR_ERR_DATA : (addr ^ (32'h5A5A_0000 + tgt));
    exp_resp[p][exp_cnt[p]] = (tgt == 2) ? `XBAR_RESP_DECERR : `XBAR_RESP_OKAY;
    exp_id[p][exp_cnt[p]]   = id;
    exp_cnt[p]++;
    slv_ar_valid[p] = 1'b1;
    slv_ar_addr[p]  = addr;
    slv_ar_id[p]    = id;
    @(negedge clk_i);
    while (!slv_ar_ready[p]) @(negedge clk_i);
    @(posedge clk_i);
    #10;
    slv_ar_valid[p] = 1'b0;
  endtask

  // Polls 10 ns after a rising edge and returns there, ready for the next drive
  task automatic check_port(int p);
    int n;
    while (rx_cnt[p] < exp_cnt[p]) begin
      @(posedge clk_i);
      #10;
    end
    while (chk_idx[p] < exp_cnt[p]) begin
      n = chk_idx[p];
      if (rx_data[p][n] !== exp_data[p][n])
        report_error($sformatf("port %0d read %0d data %h, expected %h", p, n,
                               rx_data[p][n], exp_data[p][n]));
      if (rx_resp[p][n] !== exp_resp[p][n])
        report_error($sformatf("port %0d read %0d resp %0d, expected %0d", p, n,
                               rx_resp[p][n], exp_resp[p][n]));
      if (rx_id[p][n] !== exp_id[p][n])
        report_error($sformatf("port %0d read %0d id %0d, expected %0d", p, n,
                               rx_id[p][n], exp_id[p][n]));
      chk_idx[p]++;
    end
  endtask

  task automatic finish_test(string name, int errs_before);
    if (err_cnt == errs_before) begin
      $display("PASS %s", name);
      tests_ok++;
    end else begin
      $display("FAIL %s", name);
      tests_bad++;
    end
  endtask

  task automatic test_basic_reads();
    int e0 = err_cnt;
    logic [31:0] addrs[2] = '{32'h0000_0124, 32'h0001_0ab8};
    for (int p = 0; p < 2; p++) begin
      for (int t = 0; t < 2; t++) begin
        issue_ar(p, addrs[t] + p * 4, 2'(p + 2 * t));
        check_port(p);
        if (last_src[t] !== 1'(p))
          report_error($sformatf("target %0d saw src %0d, expected %0d", t, last_src[t], p));
      end
    end
    finish_test("basic reads", e0);
  endtask

  task automatic test_decode_error();
    int e0 = err_cnt;
    int seen0 = ar_seen[0];
    int seen1 = ar_seen[1];
    issue_ar(0, 32'h0000_2000, 2'd1);
    issue_ar(1, 32'h8000_0040, 2'd2);
    check_port(0);
    check_port(1);
    if (ar_seen[0] != seen0 || ar_seen[1] != seen1)
      report_error("a target received an AR for an unmapped address");
    finish_test("decode error", e0);
  endtask

  task automatic test_same_target();
    int e0 = err_cnt;
    fork
      issue_ar(0, 32'h0001_0010, 2'd3);
      issue_ar(1, 32'h0001_0020, 2'd0);
    join
    check_port(0);
    check_port(1);
    finish_test("same target contention", e0);
  endtask

  task automatic test_r_backpressure();
    int e0 = err_cnt;
    logic [31:0] d;
    logic [1:0]  id;
    slv_r_ready[0] = 1'b0;
    issue_ar(0, 32'h0000_0800, 2'd2);
    @(negedge clk_i);
    while (!slv_r_valid[0]) @(negedge clk_i);
    d  = slv_r_data[0];
    id = slv_r_id[0];
    repeat (4) begin
      @(negedge clk_i);
      if (!slv_r_valid[0] || slv_r_data[0] !== d || slv_r_id[0] !== id)
        report_error("R changed while ready was low");
    end
    @(posedge clk_i);
    #10;
    slv_r_ready[0] = 1'b1;
    check_port(0);
    finish_test("R back-pressure", e0);
  endtask

  task automatic test_issue_order();
    int e0 = err_cnt;
    issue_ar(1, 32'h0000_0040, 2'd0);
    issue_ar(1, 32'h0001_0044, 2'd1);
    issue_ar(1, 32'h0003_0000, 2'd2);
    check_port(1);
    finish_test("issue order", e0);
  endtask

  function automatic logic [31:0] random_addr();
    logic [31:0] r;
    r = lcg_next();
    case (r[31:30] % 3)
      0:       return `XBAR_MST0_BASE + (r & 32'h0000_0FFC);
      1:       return `XBAR_MST1_BASE + (r & 32'h0000_0FFC);
      default: return 32'h0002_0000 + (r & 32'h0000_FFFC);
    endcase
  endfunction

  task automatic random_reads(int p);
    for (int n = 0; n < 10; n++) begin
      issue_ar(p, rnd_addr[p][n], rnd_id[p][n]);
    end
  endtask

  task automatic test_random_reads();
    int e0 = err_cnt;
    for (int p = 0; p < 2; p++) begin
      for (int n = 0; n < 10; n++) begin
        rnd_addr[p][n] = random_addr();
        rnd_id[p][n]   = 2'(lcg_next() >> 7);
      end
    end
    fork
      random_reads(0);
      random_reads(1);
    join
    check_port(0);
    check_port(1);
    finish_test("random reads", e0);
  endtask

  initial begin
    rst_n_i      = 1'b0;
    slv_ar_valid = '0;
    slv_ar_addr  = '0;
    slv_ar_id    = '0;
    slv_r_ready  = 2'b11;
    repeat (8) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;
    test_basic_reads();
    test_decode_error();
    test_same_target();
    test_r_backpressure();
    test_issue_order();
    test_random_reads();
    $display("Tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, err_cnt);
    if (err_cnt == 0 && tests_bad == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== source/xbar_rd_top.sv ====
/*
  Read-only crossbar top level.
  One router and one error responder per initiator port, one arbiter per
  target port, and the cross wiring that turns lane j of router i into
  input i of arbiter j.
*/
`timescale 1ns/100ps
`include "xbar_config.svh"

module xbar_rd_top (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  // Initiator ports
  input  logic              [`XBAR_NUM_SLV-1:0]     slv_ar_valid_i,
  input  xbar_pkg::addr_t   [`XBAR_NUM_SLV-1:0]     slv_ar_addr_i,
  input  xbar_pkg::slv_id_t [`XBAR_NUM_SLV-1:0]     slv_ar_id_i,
  output logic              [`XBAR_NUM_SLV-1:0]     slv_ar_ready_o,
  output logic              [`XBAR_NUM_SLV-1:0]     slv_r_valid_o,
  output xbar_pkg::data_t   [`XBAR_NUM_SLV-1:0]     slv_r_data_o,
  output xbar_pkg::resp_t   [`XBAR_NUM_SLV-1:0]     slv_r_resp_o,
  output xbar_pkg::slv_id_t [`XBAR_NUM_SLV-1:0]     slv_r_id_o,
  input  logic              [`XBAR_NUM_SLV-1:0]     slv_r_ready_i,
  // Target ports
  output logic              [`XBAR_NUM_MST-1:0]     mst_ar_valid_o,
  output xbar_pkg::addr_t   [`XBAR_NUM_MST-1:0]     mst_ar_addr_o,
  output xbar_pkg::mst_id_t [`XBAR_NUM_MST-1:0]     mst_ar_id_o,
  input  logic              [`XBAR_NUM_MST-1:0]     mst_ar_ready_i,
  input  logic              [`XBAR_NUM_MST-1:0]     mst_r_valid_i,
  input  xbar_pkg::data_t   [`XBAR_NUM_MST-1:0]     mst_r_data_i,
  input  xbar_pkg::resp_t   [`XBAR_NUM_MST-1:0]     mst_r_resp_i,
  input  xbar_pkg::mst_id_t [`XBAR_NUM_MST-1:0]     mst_r_id_i,
  output logic              [`XBAR_NUM_MST-1:0]     mst_r_ready_o
);

  // Router side, indexed [initiator][lane]
  logic              [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST:0] dmx_ar_valid, dmx_ar_ready;
  logic              [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST:0] dmx_r_valid, dmx_r_ready;
  xbar_pkg::addr_t   [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST:0] dmx_ar_addr;
  xbar_pkg::slv_id_t [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST:0] dmx_ar_id, dmx_r_id;
  xbar_pkg::data_t   [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST:0] dmx_r_data;
  xbar_pkg::resp_t   [`XBAR_NUM_SLV-1:0][`XBAR_NUM_MST:0] dmx_r_resp;

  // Arbiter side, indexed [target][initiator]
  logic              [`XBAR_NUM_MST-1:0][`XBAR_NUM_SLV-1:0] mux_ar_valid, mux_ar_ready;
  logic              [`XBAR_NUM_MST-1:0][`XBAR_NUM_SLV-1:0] mux_r_valid, mux_r_ready;
  xbar_pkg::addr_t   [`XBAR_NUM_MST-1:0][`XBAR_NUM_SLV-1:0] mux_ar_addr;
  xbar_pkg::slv_id_t [`XBAR_NUM_MST-1:0][`XBAR_NUM_SLV-1:0] mux_ar_id, mux_r_id;
  xbar_pkg::data_t   [`XBAR_NUM_MST-1:0][`XBAR_NUM_SLV-1:0] mux_r_data;
  xbar_pkg::resp_t   [`XBAR_NUM_MST-1:0][`XBAR_NUM_SLV-1:0] mux_r_resp;

  for (genvar i = 0; i < `XBAR_NUM_SLV; i++) begin : gen_slv
    xbar_rd_demux i_demux (
      .clk_i, .rst_n_i,
      .slv_ar_valid_i (slv_ar_valid_i[i]), .slv_ar_addr_i  (slv_ar_addr_i[i]),
      .slv_ar_id_i    (slv_ar_id_i[i]),    .slv_ar_ready_o (slv_ar_ready_o[i]),
      .slv_r_valid_o  (slv_r_valid_o[i]),  .slv_r_data_o   (slv_r_data_o[i]),
      .slv_r_resp_o   (slv_r_resp_o[i]),   .slv_r_id_o     (slv_r_id_o[i]),
      .slv_r_ready_i  (slv_r_ready_i[i]),
      .lane_ar_valid_o (dmx_ar_valid[i]), .lane_ar_addr_o (dmx_ar_addr[i]),
      .lane_ar_id_o    (dmx_ar_id[i]),    .lane_ar_ready_i (dmx_ar_ready[i]),
      .lane_r_valid_i  (dmx_r_valid[i]),  .lane_r_data_i  (dmx_r_data[i]),
      .lane_r_resp_i   (dmx_r_resp[i]),   .lane_r_id_i    (dmx_r_id[i]),
      .lane_r_ready_o  (dmx_r_ready[i])
    );

    // Last lane terminates unmapped reads
    xbar_err_slv i_err_slv (
      .clk_i, .rst_n_i,
      .ar_valid_i (dmx_ar_valid[i][`XBAR_NUM_MST]), .ar_id_i   (dmx_ar_id[i][`XBAR_NUM_MST]),
      .ar_ready_o (dmx_ar_ready[i][`XBAR_NUM_MST]), .r_valid_o (dmx_r_valid[i][`XBAR_NUM_MST]),
      .r_data_o   (dmx_r_data[i][`XBAR_NUM_MST]),   .r_resp_o  (dmx_r_resp[i][`XBAR_NUM_MST]),
      .r_id_o     (dmx_r_id[i][`XBAR_NUM_MST]),     .r_ready_i (dmx_r_ready[i][`XBAR_NUM_MST])
    );

    for (genvar j = 0; j < `XBAR_NUM_MST; j++) begin : gen_cross
      assign mux_ar_valid[j][i] = dmx_ar_valid[i][j];
      assign mux_ar_addr[j][i]  = dmx_ar_addr[i][j];
      assign mux_ar_id[j][i]    = dmx_ar_id[i][j];
      assign mux_r_ready[j][i]  = dmx_r_ready[i][j];
      assign dmx_ar_ready[i][j] = mux_ar_ready[j][i];
      assign dmx_r_valid[i][j]  = mux_r_valid[j][i];
      assign dmx_r_data[i][j]   = mux_r_data[j][i];
      assign dmx_r_resp[i][j]   = mux_r_resp[j][i];
      assign dmx_r_id[i][j]     = mux_r_id[j][i];
    end
  end

  for (genvar j = 0; j < `XBAR_NUM_MST; j++) begin : gen_mst
    xbar_rd_mux i_mux (
      .clk_i, .rst_n_i,
      .in_ar_valid_i (mux_ar_valid[j]), .in_ar_addr_i  (mux_ar_addr[j]),
      .in_ar_id_i    (mux_ar_id[j]),    .in_ar_ready_o (mux_ar_ready[j]),
      .in_r_valid_o  (mux_r_valid[j]),  .in_r_data_o   (mux_r_data[j]),
      .in_r_resp_o   (mux_r_resp[j]),   .in_r_id_o     (mux_r_id[j]),
      .in_r_ready_i  (mux_r_ready[j]),
      .mst_ar_valid_o (mst_ar_valid_o[j]), .mst_ar_addr_o  (mst_ar_addr_o[j]),
      .mst_ar_id_o    (mst_ar_id_o[j]),    .mst_ar_ready_i (mst_ar_ready_i[j]),
      .mst_r_valid_i  (mst_r_valid_i[j]),  .mst_r_data_i   (mst_r_data_i[j]),
      .mst_r_resp_i   (mst_r_resp_i[j]),   .mst_r_id_i     (mst_r_id_i[j]),
      .mst_r_ready_o  (mst_r_ready_o[j])
    );
  end

endmodule

// ==== source/xbar_rd_mux.sv ====
/*
  Per-target read arbiter.
  Round-robin over the initiator lanes with the grant held through a stalled
  AR. The winner's port number is prepended to the ID, and R is steered back
  by that field with the field stripped off.
*/
`timescale 1ns/100ps
`include "xbar_config.svh"

module xbar_rd_mux (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  // Input side, one lane per initiator port
  input  logic              [`XBAR_NUM_SLV-1:0]     in_ar_valid_i,
  input  xbar_pkg::addr_t   [`XBAR_NUM_SLV-1:0]     in_ar_addr_i,
  input  xbar_pkg::slv_id_t [`XBAR_NUM_SLV-1:0]     in_ar_id_i,
  output logic              [`XBAR_NUM_SLV-1:0]     in_ar_ready_o,
  output logic              [`XBAR_NUM_SLV-1:0]     in_r_valid_o,
  output xbar_pkg::data_t   [`XBAR_NUM_SLV-1:0]     in_r_data_o,
  output xbar_pkg::resp_t   [`XBAR_NUM_SLV-1:0]     in_r_resp_o,
  output xbar_pkg::slv_id_t [`XBAR_NUM_SLV-1:0]     in_r_id_o,
  input  logic              [`XBAR_NUM_SLV-1:0]     in_r_ready_i,
  // Target side
  output logic                                      mst_ar_valid_o,
  output xbar_pkg::addr_t                           mst_ar_addr_o,
  output xbar_pkg::mst_id_t                         mst_ar_id_o,
  input  logic                                      mst_ar_ready_i,
  input  logic                                      mst_r_valid_i,
  input  xbar_pkg::data_t                           mst_r_data_i,
  input  xbar_pkg::resp_t                           mst_r_resp_i,
  input  xbar_pkg::mst_id_t                         mst_r_id_i,
  output logic                                      mst_r_ready_o
);

  xbar_pkg::src_idx_t rr_q;
  xbar_pkg::src_idx_t lock_idx_q;
  xbar_pkg::src_idx_t arb_idx;
  xbar_pkg::src_idx_t gnt;
  xbar_pkg::src_idx_t r_src;
  logic               lock_q;
  logic               arb_found;

  // Search starts one past the last winner
  always_comb begin
    arb_idx   = rr_q;
    arb_found = 1'b0;
    for (int k = 1; k <= `XBAR_NUM_SLV; k++) begin
      if (!arb_found && in_ar_valid_i[(int'(rr_q) + k) % `XBAR_NUM_SLV]) begin
        arb_idx   = xbar_pkg::src_idx_t'((int'(rr_q) + k) % `XBAR_NUM_SLV);
        arb_found = 1'b1;
      end
    end
  end

  assign gnt = lock_q ? lock_idx_q : arb_idx;

  always_comb begin
    mst_ar_valid_o         = in_ar_valid_i[gnt];
    mst_ar_addr_o          = in_ar_addr_i[gnt];
    mst_ar_id_o.fields.src = gnt;
    mst_ar_id_o.fields.id  = in_ar_id_i[gnt];
    for (int k = 0; k < `XBAR_NUM_SLV; k++) begin
      in_ar_ready_o[k] = mst_ar_ready_i && (gnt == xbar_pkg::src_idx_t'(k));
    end
  end

  // Response routing by the source field
  assign r_src         = mst_r_id_i.fields.src;
  assign mst_r_ready_o = in_r_ready_i[r_src];

  always_comb begin
    for (int k = 0; k < `XBAR_NUM_SLV; k++) begin
      in_r_valid_o[k] = mst_r_valid_i && (r_src == xbar_pkg::src_idx_t'(k));
      in_r_data_o[k]  = mst_r_data_i;
      in_r_resp_o[k]  = mst_r_resp_i;
      in_r_id_o[k]    = mst_r_id_i.fields.id;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q <= mst_ar_valid_o && !mst_ar_ready_i;
      if (mst_ar_valid_o) begin
        lock_idx_q <= gnt;
      end
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        rr_q <= gnt;
      end
    end
  end

  grant_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mst_ar_valid_o && !mst_ar_ready_i) |=> (gnt == $past(gnt)))
    else $error("Grant changed while AR was stalled");

endmodule

// ==== source/xbar_err_slv.sv ====
/*
  Decode error responder, one per initiator port.
  Accepts one read at a time and answers it on the next cycle with DECERR,
  the error data pattern and the ID of the request.
*/
`timescale 1ns/100ps
`include "xbar_config.svh"

module xbar_err_slv (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              ar_valid_i,
  input  xbar_pkg::slv_id_t ar_id_i,
  output logic              ar_ready_o,
  output logic              r_valid_o,
  output xbar_pkg::data_t   r_data_o,
  output xbar_pkg::resp_t   r_resp_o,
  output xbar_pkg::slv_id_t r_id_o,
  input  logic              r_ready_i
);

  logic              busy_q;
  xbar_pkg::slv_id_t id_q;

  // Idle means ready for a new read
  assign ar_ready_o = !busy_q;
  assign r_valid_o  = busy_q;
  assign r_data_o   = `XBAR_ERR_DATA;
  assign r_resp_o   = `XBAR_RESP_DECERR;
  assign r_id_o     = id_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (ar_valid_i && ar_ready_o) begin
      busy_q <= 1'b1;
    end else if (r_valid_o && r_ready_i) begin
      busy_q <= 1'b0;
    end
  end

  // ID of the read being answered
  always_ff @(posedge clk_i) begin
    if (ar_valid_i && ar_ready_o) begin
      id_q <= ar_id_i;
    end
  end

endmodule

// ==== source/xbar_rd_demux.sv ====
/*
  Per-initiator read router.
  Sends each AR to the lane chosen by the decoder, lane NUM_MST being the
  error responder, and returns R from the locked lane only. A target switch
  waits until all outstanding reads are back, keeping responses in order.
*/
`timescale 1ns/100ps
`include "xbar_config.svh"

module xbar_rd_demux (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  // Initiator side
  input  logic                                    slv_ar_valid_i,
  input  xbar_pkg::addr_t                         slv_ar_addr_i,
  input  xbar_pkg::slv_id_t                       slv_ar_id_i,
  output logic                                    slv_ar_ready_o,
  output logic                                    slv_r_valid_o,
  output xbar_pkg::data_t                         slv_r_data_o,
  output xbar_pkg::resp_t                         slv_r_resp_o,
  output xbar_pkg::slv_id_t                       slv_r_id_o,
  input  logic                                    slv_r_ready_i,
  // Lane side, muxes first and the error responder last
  output logic              [`XBAR_NUM_MST:0]     lane_ar_valid_o,
  output xbar_pkg::addr_t   [`XBAR_NUM_MST:0]     lane_ar_addr_o,
  output xbar_pkg::slv_id_t [`XBAR_NUM_MST:0]     lane_ar_id_o,
  input  logic              [`XBAR_NUM_MST:0]     lane_ar_ready_i,
  input  logic              [`XBAR_NUM_MST:0]     lane_r_valid_i,
  input  xbar_pkg::data_t   [`XBAR_NUM_MST:0]     lane_r_data_i,
  input  xbar_pkg::resp_t   [`XBAR_NUM_MST:0]     lane_r_resp_i,
  input  xbar_pkg::slv_id_t [`XBAR_NUM_MST:0]     lane_r_id_i,
  output logic              [`XBAR_NUM_MST:0]     lane_r_ready_o
);

  localparam int unsigned cnt_w = $clog2(`XBAR_MAX_TRANS + 1);

  xbar_pkg::tgt_idx_t dec_idx;
  xbar_pkg::tgt_idx_t sel;
  xbar_pkg::tgt_idx_t lock_q;
  logic               dec_err;
  logic [cnt_w-1:0]   cnt_q;
  logic               stall;
  logic               ar_fire;
  logic               r_fire;

  xbar_addr_decode i_addr_decode (
    .addr_i      (slv_ar_addr_i),
    .idx_o       (dec_idx),
    .dec_error_o (dec_err)
  );

  assign sel = dec_err ? xbar_pkg::tgt_idx_t'(`XBAR_NUM_MST) : dec_idx;

  // Hold AR when full, or when it would switch targets with reads in flight
  assign stall = (cnt_q == cnt_w'(`XBAR_MAX_TRANS)) ||
                 ((cnt_q != '0) && (sel != lock_q));

  assign slv_ar_ready_o = !stall && lane_ar_ready_i[sel];
  assign ar_fire        = slv_ar_valid_i && slv_ar_ready_o;

  always_comb begin
    for (int k = 0; k <= `XBAR_NUM_MST; k++) begin
      lane_ar_valid_o[k] = slv_ar_valid_i && !stall && (sel == xbar_pkg::tgt_idx_t'(k));
      lane_ar_addr_o[k]  = slv_ar_addr_i;
      lane_ar_id_o[k]    = slv_ar_id_i;
      lane_r_ready_o[k]  = slv_r_ready_i && (lock_q == xbar_pkg::tgt_idx_t'(k));
    end
  end

  // Only the locked lane can hold responses for this port
  assign slv_r_valid_o = lane_r_valid_i[lock_q];
  assign slv_r_data_o  = lane_r_data_i[lock_q];
  assign slv_r_resp_o  = lane_r_resp_i[lock_q];
  assign slv_r_id_o    = lane_r_id_i[lock_q];
  assign r_fire        = slv_r_valid_o && slv_r_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      lock_q <= '0;
    end else begin
      if (ar_fire) begin
        lock_q <= sel;
      end
      case ({ar_fire, r_fire})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  ar_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (slv_ar_valid_i && !slv_ar_ready_o) |=> $stable(slv_ar_addr_i))
    else $error("AR address changed while waiting for ready");

  cnt_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_q <= cnt_w'(`XBAR_MAX_TRANS))
    else $error("Outstanding counter above limit");

endmodule

// ==== source/xbar_addr_decode.sv ====
/*
  Address decoder for the fixed two-region map.
  Returns the target index of the matching region, or NUM_MST together
  with the error flag when the address is unmapped. Purely combinational.
*/
`timescale 1ns/100ps
`include "xbar_config.svh"

module xbar_addr_decode (
  input  xbar_pkg::addr_t    addr_i,
  output xbar_pkg::tgt_idx_t idx_o,
  output logic               dec_error_o
);

  logic hit_mst0;
  logic hit_mst1;

  // Regions are half open, base included and end excluded
  assign hit_mst0 = (addr_i >= `XBAR_MST0_BASE) && (addr_i < `XBAR_MST0_END);
  assign hit_mst1 = (addr_i >= `XBAR_MST1_BASE) && (addr_i < `XBAR_MST1_END);

  always_comb begin
    idx_o       = xbar_pkg::tgt_idx_t'(`XBAR_NUM_MST);
    dec_error_o = 1'b1;
    if (hit_mst0) begin
      idx_o       = xbar_pkg::tgt_idx_t'(0);
      dec_error_o = 1'b0;
    end else if (hit_mst1) begin
      idx_o       = xbar_pkg::tgt_idx_t'(1);
      dec_error_o = 1'b0;
    end
  end

endmodule

// ==== source/xbar_pkg.sv ====
/*
  Shared types of the read crossbar.
  Refer to them by scoped name from the RTL and the testbench.
*/
`include "xbar_config.svh"

package xbar_pkg;

  localparam int unsigned src_idx_w = (`XBAR_NUM_SLV > 1) ? $clog2(`XBAR_NUM_SLV) : 1;
  localparam int unsigned tgt_idx_w = $clog2(`XBAR_NUM_MST + 1);
  localparam int unsigned mst_id_w  = src_idx_w + `XBAR_ID_WIDTH;

  typedef logic [`XBAR_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`XBAR_DATA_WIDTH-1:0] data_t;
  typedef logic [1:0]                  resp_t;
  typedef logic [`XBAR_ID_WIDTH-1:0]   slv_id_t;

  // Initiator port number, carried in the upper ID bits on the target side
  typedef logic [src_idx_w-1:0] src_idx_t;

  // Index NUM_MST selects the decode error responder
  typedef logic [tgt_idx_w-1:0] tgt_idx_t;

  // Target-side ID, seen flat by the targets and split by the muxes
  typedef union packed {
    logic [mst_id_w-1:0] raw;
    struct packed {
      src_idx_t src;
      slv_id_t  id;
    } fields;
  } mst_id_t;

endpackage

// ==== source/xbar_config.svh ====
/*
  Build-time configuration of the read crossbar.
  Widths, port counts, the outstanding limit, the fixed address map and
  the response codes. Include wherever one of these values is needed.
*/
`ifndef XBAR_CONFIG_SVH
`define XBAR_CONFIG_SVH

`define XBAR_ADDR_WIDTH 32
`define XBAR_DATA_WIDTH 32
`define XBAR_ID_WIDTH 2
`define XBAR_NUM_SLV 2
`define XBAR_NUM_MST 2
`define XBAR_MAX_TRANS 4

// Region ends are exclusive
`define XBAR_MST0_BASE 32'h0000_0000
`define XBAR_MST0_END 32'h0000_1000
`define XBAR_MST1_BASE 32'h0001_0000
`define XBAR_MST1_END 32'h0001_1000

`define XBAR_RESP_OKAY 2'd0
`define XBAR_RESP_DECERR 2'd3
`define XBAR_ERR_DATA 32'hBADC_0DE5

`endif
